// File: scalerPkg.sv
`default_nettype none

package scalerPkg;
	localparam int pixelW = 8;	// One grey channel
	localparam int coordW = 11;	// Up to 2048 pixels per axis
	localparam int fracBits = 8;	// Blend weight resolution
	localparam int scaleIntBits = 4;
	localparam int scaleFracBits = 14;
	localparam int coeffW = fracBits + 1;	// Q1.8, so 1.0 fits
	localparam int posW = coordW + scaleFracBits;

	typedef logic [pixelW-1:0] pixel_t;
	typedef logic [coordW-1:0] coord_t;
	typedef logic [scaleIntBits+scaleFracBits-1:0] scale_t;	// Q4.14
	typedef logic [coeffW-1:0] coeff_t;

	localparam coeff_t coeffOne = coeff_t'(1 << fracBits);
	localparam coeff_t coeffHalf = coeff_t'(1 << (fracBits - 1));

	// All resolutions are stored minus one
	typedef struct packed {
		coord_t inXRes;
		coord_t inYRes;
		coord_t outXRes;
		coord_t outYRes;
		scale_t xScale;	// Input step per output pixel
		scale_t yScale;
		logic nearest;	// Nearest neighbour instead of bilinear
	} scaleCfg_t;

	// Neighbourhood, row first then column
	typedef struct packed {
		pixel_t p00;
		pixel_t p01;
		pixel_t p10;
		pixel_t p11;
	} quadPix_t;

	typedef struct packed {
		coeff_t p00;
		coeff_t p01;
		coeff_t p10;
		coeff_t p11;
	} quadCoeff_t;

	typedef struct packed {
		coord_t pix;	// Integer input pixel index
		logic [scaleFracBits-1:0] frac;	// Top fracBits give the weight
	} posFields_t;

	// Product of a count and a scale factor
	typedef union packed {
		logic [posW-1:0] raw;
		posFields_t part;
	} scalePos_t;
endpackage

`default_nettype wire

// File: lineBuffer.sv
`default_nettype none

module lineBuffer import scalerPkg::*; #(
	parameter int bufferDepth = 4,
	localparam int fillW = $clog2(bufferDepth + 1),
	localparam int ptrW = $clog2(bufferDepth)
) (
	input logic clk,
	input logic start,
	input logic wrEn,
	input coord_t wrAddr,
	input pixel_t wrData,
	input logic advanceWrite,
	input logic advanceRead1,
	input logic advanceRead2,
	input coord_t rdAddr,
	output logic [fillW-1:0] fillCount,
	output quadPix_t taps
);
	localparam logic [ptrW-1:0] lastPtr = ptrW'(bufferDepth - 1);

	pixel_t lineMem [bufferDepth][1 << coordW];	// One memory per line
	logic [ptrW-1:0] wrPtr;	// Line being filled
	logic [ptrW-1:0] rdPtr;	// Upper line of the read pair
	logic [ptrW-1:0] rdPtrNext;
	coord_t rdAddrNext;

	// Ring step, depth need not be a power of two
	function automatic logic [ptrW-1:0] ptrInc(input logic [ptrW-1:0] p);
		return (p == lastPtr) ? '0 : p + 1'b1;
	endfunction

	assign rdPtrNext = ptrInc(rdPtr);	// Lower line of the pair
	assign rdAddrNext = rdAddr + 1'b1;

	always_ff @(posedge clk or posedge start)
	begin
		if (start)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
		end
		else
		begin
			if (advanceWrite)
				wrPtr <= ptrInc(wrPtr);
			if (advanceRead2)
				rdPtr <= ptrInc(rdPtrNext);	// Skip two lines
			else if (advanceRead1)
				rdPtr <= rdPtrNext;
			// Count of complete lines not yet released by the reader
			fillCount <= fillCount + fillW'(advanceWrite) - fillW'(advanceRead1)
				- (advanceRead2 ? fillW'(2) : '0);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			lineMem[wrPtr][wrAddr] <= wrData;
		taps.p00 <= lineMem[rdPtr][rdAddr];	// Top left
		taps.p01 <= lineMem[rdPtr][rdAddrNext];
		taps.p10 <= lineMem[rdPtrNext][rdAddr];
		taps.p11 <= lineMem[rdPtrNext][rdAddrNext];	// Bottom right
	end
endmodule

`default_nettype wire

// File: lineWriter.sv
`default_nettype none

module lineWriter import scalerPkg::*; #(
	parameter int bufferDepth = 4,
	localparam int fillW = $clog2(bufferDepth + 1)
) (
	input logic clk,
	input logic start,
	input scaleCfg_t cfg,
	input pixel_t dIn,
	input logic dInValid,
	input logic [fillW-1:0] fillCount,
	output logic nextDin,
	output logic wrEn,
	output coord_t wrAddr,
	output pixel_t wrData,
	output logic advanceWrite,
	output logic readyForRead,
	output logic allWritten
);
	typedef enum logic [1:0] {wrIdle, wrRead, wrDone} wrState_t;

	wrState_t wrState;
	coord_t colCount;
	coord_t rowCount;	// Input row being taken
	coord_t wrOutLine;	// Output line whose top row is looked up next
	coord_t nextTop;	// First top row above rowCount
	coord_t lastTop;	// Latest top row at or below rowCount
	scalePos_t topPos;
	logic discard;	// Current row is not needed
	logic settled;
	logic accept;
	logic rowEnd;

	assign topPos.raw = posW'(wrOutLine) * posW'(cfg.yScale);
	assign settled = nextTop > rowCount;	// Lookup has caught up
	assign nextDin = wrState == wrRead && settled && fillCount < fillW'(bufferDepth);
	assign accept = dInValid && nextDin;
	assign rowEnd = accept && colCount == cfg.inXRes;
	assign wrEn = accept && !discard;
	assign wrAddr = colCount;
	assign wrData = dIn;
	assign advanceWrite = rowEnd && !discard;	// Completed line joins the ring
	assign allWritten = wrState == wrDone;

	// Walk output lines until their top row passes the current row
	always_ff @(posedge clk or posedge start)
	begin
		if (start)
		begin
			wrOutLine <= '0;
			nextTop <= '0;
			lastTop <= '0;
		end
		else if (!settled)
		begin
			lastTop <= nextTop;
			if (wrOutLine > cfg.outYRes)
				nextTop <= '1;	// No more output lines
			else
			begin
				nextTop <= topPos.part.pix;
				wrOutLine <= wrOutLine + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge start)
	begin
		if (start)
		begin
			wrState <= wrIdle;
			colCount <= '0;
			rowCount <= '0;
			discard <= 1'b0;	// Row 0 is always a top row
			readyForRead <= 1'b0;
		end
		else
		begin
			case (wrState)
				wrIdle: wrState <= wrRead;
				wrRead:
				begin
					if (rowEnd)
					begin
						colCount <= '0;
						rowCount <= rowCount + 1'b1;
						// Keep the next row if it is a top row or the one under a top row
						discard <= !(nextTop == rowCount + 1'b1 || lastTop == rowCount);
						if (rowCount == coordW'(1))
							readyForRead <= 1'b1;
						if (rowCount == cfg.inYRes)
							wrState <= wrDone;
					end
					else if (accept)
						colCount <= colCount + 1'b1;
				end
				default: ;	// Frame taken, wait for start
			endcase
		end
	end
endmodule

`default_nettype wire

// File: coeffGen.sv
`default_nettype none

module coeffGen import scalerPkg::*; (
	input logic clk,
	input logic start,
	input scalePos_t xPos,
	input scalePos_t yPos,
	input logic nearest,
	output quadCoeff_t coeffs
);
	coeff_t xBlend;	// Weight of the right column
	coeff_t yBlend;	// Weight of the lower row
	coeff_t xInv;
	coeff_t yInv;
	logic xHigh;
	logic yHigh;

	// Q1.8 product rounded to nearest
	function automatic coeff_t roundMul(input coeff_t a, input coeff_t b);
		logic [2*coeffW-1:0] prod;
		prod = a * b + (coeffHalf - 1'b1);
		return prod[fracBits +: coeffW];
	endfunction

	assign xInv = coeffOne - xBlend;
	assign yInv = coeffOne - yBlend;
	assign xHigh = xBlend >= coeffHalf;	// Closer to the right column
	assign yHigh = yBlend >= coeffHalf;

	always_ff @(posedge clk or posedge start)
	begin
		if (start)
		begin
			xBlend <= '0;
			yBlend <= '0;
			coeffs <= '0;
		end
		else
		begin
			// y is sampled too, it changes right after a line's last column
			xBlend <= {1'b0, xPos.part.frac[scaleFracBits-1 -: fracBits]};
			yBlend <= {1'b0, yPos.part.frac[scaleFracBits-1 -: fracBits]};
			if (nearest)
			begin
				coeffs.p00 <= (!xHigh && !yHigh) ? coeffOne : '0;
				coeffs.p01 <= (xHigh && !yHigh) ? coeffOne : '0;
				coeffs.p10 <= (!xHigh && yHigh) ? coeffOne : '0;
				coeffs.p11 <= (xHigh && yHigh) ? coeffOne : '0;
			end
			else
			begin
				coeffs.p00 <= roundMul(xInv, yInv);
				coeffs.p01 <= roundMul(xBlend, yInv);
				coeffs.p10 <= roundMul(xInv, yBlend);
				coeffs.p11 <= roundMul(xBlend, yBlend);
			end
		end
	end
endmodule

`default_nettype wire

// File: blendPipe.sv
`default_nettype none

module blendPipe import scalerPkg::*; (
	input logic clk,
	input logic start,
	input quadPix_t taps,
	input quadCoeff_t coeffs,
	input logic lastCol,
	input logic issue,
	output pixel_t dOut,
	output logic dOutValid
);
	localparam int prodW = pixelW + coeffW;

	quadPix_t tapReg;
	logic lastColD;	// Lined up with the buffer read
	logic [prodW-1:0] prod00, prod01, prod10, prod11;
	logic [prodW+1:0] sum;	// Room for four products
	logic [2:0] validPipe;

	assign sum = {2'b00, prod00} + {2'b00, prod01} + {2'b00, prod10} + {2'b00, prod11};

	always_ff @(posedge clk)
	begin
		lastColD <= lastCol;
		tapReg.p00 <= taps.p00;
		tapReg.p01 <= lastColD ? taps.p00 : taps.p01;	// Replicate the edge column
		tapReg.p10 <= taps.p10;
		tapReg.p11 <= lastColD ? taps.p10 : taps.p11;
		prod00 <= tapReg.p00 * coeffs.p00;
		prod01 <= tapReg.p01 * coeffs.p01;
		prod10 <= tapReg.p10 * coeffs.p10;
		prod11 <= tapReg.p11 * coeffs.p11;
		dOut <= sum[fracBits +: pixelW];	// Drop the Q1.8 fraction
	end

	// Valid follows read, tap, product and sum stages
	always_ff @(posedge clk or posedge start)
	begin
		if (start)
		begin
			validPipe <= '0;
			dOutValid <= 1'b0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], issue};
			dOutValid <= validPipe[2];
		end
	end
endmodule

`default_nettype wire

// File: scaleControl.sv
`default_nettype none

module scaleControl import scalerPkg::*; #(
	parameter int bufferDepth = 4,
	localparam int fillW = $clog2(bufferDepth + 1)
) (
	input logic clk,
	input logic start,
	input scaleCfg_t cfg,
	input logic readyForRead,
	input logic allWritten,
	input logic nextDout,
	input logic [fillW-1:0] fillCount,
	output coord_t rdAddr,
	output logic advanceRead1,
	output logic advanceRead2,
	output logic issue,
	output logic lastCol,
	output scalePos_t xPos,
	output scalePos_t yPos
);
	typedef enum logic [1:0] {rdStart, rdLine, rdDone} rdState_t;

	rdState_t rdState;
	coord_t outCol;	// Output column being issued
	coord_t outLine;
	scalePos_t yPosNext;	// Look-ahead for the following line
	logic validInt;	// Buffer holds the lines this output line needs
	logic lineStall;	// Gap while the read pointer moves

	assign issue = nextDout && validInt && !lineStall;
	assign rdAddr = xPos.part.pix;
	assign lastCol = xPos.part.pix == cfg.inXRes;	// Right taps fall off the line

	always_ff @(posedge clk or posedge start)
	begin
		if (start)
		begin
			rdState <= rdStart;
			outCol <= '0;
			outLine <= '0;
			xPos <= '0;
			yPos <= '0;
			yPosNext <= '0;
			validInt <= 1'b0;
			lineStall <= 1'b0;
			advanceRead1 <= 1'b0;
			advanceRead2 <= 1'b0;
		end
		else
		begin
			advanceRead1 <= 1'b0;	// Advances are single pulses
			advanceRead2 <= 1'b0;
			lineStall <= 1'b0;
			case (rdState)
				rdStart:
				begin
					if (readyForRead)	// Lines 0 and 1 are in
					begin
						rdState <= rdLine;
						validInt <= 1'b1;
					end
				end
				rdLine:
				begin
					if (issue)
					begin
						if (outCol == cfg.outXRes)
						begin
							// Move the buffer to the next line's top input line
							if (yPosNext.part.pix == yPos.part.pix + 1'b1)
							begin
								advanceRead1 <= 1'b1;
								if (fillCount < fillW'(3))
									validInt <= 1'b0;	// Wait for one more line
							end
							else if (yPosNext.part.pix > yPos.part.pix + 1'b1)
							begin
								advanceRead2 <= 1'b1;
								if (fillCount < fillW'(4))
									validInt <= 1'b0;
							end
							if (outLine == cfg.outYRes)
								rdState <= rdDone;
							outCol <= '0;
							outLine <= outLine + 1'b1;
							xPos <= '0;
							yPos <= yPosNext;
							lineStall <= 1'b1;
						end
						else
						begin
							outCol <= outCol + 1'b1;
							xPos.raw <= posW'(outCol + 1'b1) * posW'(cfg.xScale);
						end
					end
					// Fill count is stale while an advance is pending
					else if (!validInt && !advanceRead1 && !advanceRead2 &&
						(fillCount >= fillW'(2) || allWritten))
						validInt <= 1'b1;
				end
				rdDone:
				begin
					validInt <= 1'b0;
					// Drain leftover lines so the input side can finish the frame
					advanceRead1 <= !advanceRead1 && !advanceRead2 && fillCount != '0;
				end
				default: rdState <= rdStart;
			endcase
			yPosNext.raw <= posW'(outLine + 1'b1) * posW'(cfg.yScale);
		end
	end
endmodule

`default_nettype wire

// File: streamScaler.sv
`default_nettype none

module streamScaler import scalerPkg::*; #(
	parameter int bufferDepth = 4,	// Line memories in the ring
	localparam int fillW = $clog2(bufferDepth + 1)
) (
	input logic clk,
	input logic start,
	input scaleCfg_t cfg,
	input pixel_t dIn,
	input logic dInValid,
	output logic nextDin,
	output pixel_t dOut,
	output logic dOutValid,
	input logic nextDout
);
	logic wrEn;
	coord_t wrAddr;
	pixel_t wrData;
	logic advanceWrite;
	logic readyForRead;
	logic allWritten;
	logic [fillW-1:0] fillCount;
	coord_t rdAddr;
	logic advanceRead1;
	logic advanceRead2;
	logic issue;
	logic lastCol;
	scalePos_t xPos;
	scalePos_t yPos;
	quadPix_t taps;
	quadCoeff_t coeffs;

	// Input side
	lineWriter #(.bufferDepth(bufferDepth)) writer (
		.clk(clk), .start(start), .cfg(cfg), .dIn(dIn), .dInValid(dInValid),
		.fillCount(fillCount), .nextDin(nextDin), .wrEn(wrEn), .wrAddr(wrAddr),
		.wrData(wrData), .advanceWrite(advanceWrite), .readyForRead(readyForRead),
		.allWritten(allWritten)
	);

	lineBuffer #(.bufferDepth(bufferDepth)) buffer (
		.clk(clk), .start(start), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.advanceWrite(advanceWrite), .advanceRead1(advanceRead1),
		.advanceRead2(advanceRead2), .rdAddr(rdAddr), .fillCount(fillCount), .taps(taps)
	);

	// Output side
	scaleControl #(.bufferDepth(bufferDepth)) control (
		.clk(clk), .start(start), .cfg(cfg), .readyForRead(readyForRead),
		.allWritten(allWritten), .nextDout(nextDout), .fillCount(fillCount),
		.rdAddr(rdAddr), .advanceRead1(advanceRead1), .advanceRead2(advanceRead2),
		.issue(issue), .lastCol(lastCol), .xPos(xPos), .yPos(yPos)
	);

	coeffGen coeff (
		.clk(clk), .start(start), .xPos(xPos), .yPos(yPos), .nearest(cfg.nearest),
		.coeffs(coeffs)
	);

	blendPipe blend (
		.clk(clk), .start(start), .taps(taps), .coeffs(coeffs), .lastCol(lastCol),
		.issue(issue), .dOut(dOut), .dOutValid(dOutValid)
	);
endmodule

`default_nettype wire

// File: tbStreamScaler.sv
`default_nettype none

module tbStreamScaler import scalerPkg::*; ();
	localparam int maxCycles = 20000;	// Per frame
	localparam int quietCycles = 8;

	logic clk;
	logic start;
	scaleCfg_t cfg;
	pixel_t dIn;
	logic dInValid;
	logic nextDin;
	pixel_t dOut;
	logic dOutValid;
	logic nextDout;

	logic [31:0] lcgState = 32'h6fad_06e1;
	scaleCfg_t frameCfg;	// Setup of the frame under test
	pixel_t frameMem [0:24*16-1];	// Whole input frame in row-major order
	pixel_t expOut [$];	// Model output in row-major order
	int inTotal;
	int outTotal;

	streamScaler #(.bufferDepth(4)) uut (
		.clk(clk), .start(start), .cfg(cfg), .dIn(dIn), .dInValid(dInValid),
		.nextDin(nextDin), .dOut(dOut), .dOutValid(dOutValid), .nextDout(nextDout)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = lcgNext();
		return int'(r[31:16]) % n;	// Upper bits have the longer period
	endfunction

	task automatic checkEqual(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic stopOnTimeout(input string what);
		$display("Timeout at time %0t while waiting for %s", $time, what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Reference scaler for output column col of output line line
	function automatic pixel_t modelPixel(input int col, input int line);
		int xp;
		int yp;
		int xi;
		int yi;
		int xr;
		int wx;
		int wy;
		int w;
		int q00, q01, q10, q11;
		int k00, k01, k10, k11;
		int acc;
		w = int'(frameCfg.inXRes) + 1;
		xp = col * int'(frameCfg.xScale);	// Q.14 position
		yp = line * int'(frameCfg.yScale);
		xi = xp >> 14;
		yi = yp >> 14;
		wx = (xp >> 6) & 255;	// Top 8 of 14 fraction bits
		wy = (yp >> 6) & 255;
		xr = (xi == int'(frameCfg.inXRes)) ? xi : xi + 1;	// Edge column repeats
		q00 = frameMem[yi * w + xi];
		q01 = frameMem[yi * w + xr];
		q10 = frameMem[(yi + 1) * w + xi];
		q11 = frameMem[(yi + 1) * w + xr];
		if (frameCfg.nearest)
		begin
			k00 = (wx < 128 && wy < 128) ? 256 : 0;	// Half or more picks the far side
			k01 = (wx >= 128 && wy < 128) ? 256 : 0;
			k10 = (wx < 128 && wy >= 128) ? 256 : 0;
			k11 = (wx >= 128 && wy >= 128) ? 256 : 0;
		end
		else
		begin
			// Q1.8 products rounded with a bias of 127
			k00 = ((256 - wx) * (256 - wy) + 127) >> 8;
			k01 = (wx * (256 - wy) + 127) >> 8;
			k10 = ((256 - wx) * wy + 127) >> 8;
			k11 = (wx * wy + 127) >> 8;
		end
		acc = q00 * k00 + q01 * k01 + q10 * k10 + q11 * k11;
		return pixel_t'(acc >> 8);
	endfunction

	// Random sizes and scales that keep every tap inside the frame
	task automatic setupFrame(input logic nearestMode, input logic downscale);
		int inW;
		int inH;
		int outW;
		int outH;
		inW = 2 + randBelow(23);
		inH = downscale ? 16 : 2 + randBelow(15);
		outW = 2 + randBelow(31);	// Keeps xScale below 16
		outH = downscale ? 2 + randBelow(3) : 1 + randBelow(24);	// Down gives yScale > 2
		frameCfg.inXRes = coord_t'(inW - 1);
		frameCfg.inYRes = coord_t'(inH - 1);
		frameCfg.outXRes = coord_t'(outW - 1);
		frameCfg.outYRes = coord_t'(outH - 1);
		frameCfg.xScale = scale_t'((inW << 14) / outW);	// Last column at most inXRes
		frameCfg.yScale = scale_t'(((inH - 1) << 14) / outH);	// Last line below inYRes
		frameCfg.nearest = nearestMode;
		inTotal = inW * inH;
		outTotal = outW * outH;
		for (int i = 0; i < inTotal; i++)
			frameMem[i] = pixel_t'(randBelow(256));
		expOut.delete();
		for (int l = 0; l < outH; l++)
			for (int c = 0; c < outW; c++)
				expOut.push_back(modelPixel(c, l));
	endtask

	task automatic applyStart();
		@(posedge clk);
		start <= 1'b1;
		cfg <= frameCfg;
		dInValid <= 1'b0;
		nextDout <= 1'b0;
		repeat (8)
		begin
			@(negedge clk);
			checkEqual("nextDin", nextDin, 0);	// Both levels held low in reset
			checkEqual("dOutValid", dOutValid, 0);
			@(posedge clk);
		end
		start <= 1'b0;
	endtask

	// Feed the frame and check outputs until done or until abortAfter cycles
	task automatic runFrame(input logic randomReady, input int abortAfter);
		int inCount;
		int outCount;
		int cycles;
		logic taken;
		logic drive;
		inCount = 0;
		outCount = 0;
		cycles = 0;
		taken = 1'b0;
		while ((inCount < inTotal || outCount < outTotal) &&
			(abortAfter == 0 || cycles < abortAfter))
		begin
			drive = inCount < inTotal && randBelow(4) != 0;
			dInValid <= drive;
			dIn <= (inCount < inTotal) ? frameMem[inCount] : '0;
			nextDout <= randomReady ? randBelow(2) == 1 : 1'b1;
			@(negedge clk);
			taken = dInValid && nextDin;	// Pixel goes in at the next edge
			if (dOutValid)
			begin
				checkEqual("dOutValid", outCount < outTotal, 1);	// Pulse past the frame
				checkEqual("dOut", dOut, expOut[outCount]);
				outCount++;
			end
			cycles++;
			if (cycles > maxCycles)
				stopOnTimeout("the frame to finish");
			@(posedge clk);
			if (taken)
				inCount++;
		end
		dInValid <= 1'b0;
		nextDout <= 1'b1;
		if (abortAfter == 0)
		begin
			repeat (quietCycles)
			begin
				@(negedge clk);
				if (dOutValid)
					outCount++;	// Late or repeated pulse
			end
			checkEqual("outputCount", outCount,
				(frameCfg.outXRes + 1) * (frameCfg.outYRes + 1));
		end
	endtask

	initial
	begin
		start = 1'b1;
		cfg = '0;
		dIn = '0;
		dInValid = 1'b0;
		nextDout = 1'b0;
		repeat (3)	// Bilinear with the output always ready
		begin
			setupFrame(1'b0, 1'b0);
			applyStart();
			runFrame(1'b0, 0);
		end
		repeat (2)	// Nearest neighbour
		begin
			setupFrame(1'b1, 1'b0);
			applyStart();
			runFrame(1'b0, 0);
		end
		setupFrame(1'b0, 1'b0);	// Output back-pressure
		applyStart();
		runFrame(1'b1, 0);
		setupFrame(1'b1, 1'b0);
		applyStart();
		runFrame(1'b1, 0);
		repeat (2)	// Line skipping and two-line advance
		begin
			setupFrame(1'b0, 1'b1);
			applyStart();
			runFrame(1'b1, 0);
		end
		setupFrame(1'b1, 1'b1);
		applyStart();
		runFrame(1'b0, 0);
		setupFrame(1'b0, 1'b0);	// Cut off mid-frame
		applyStart();
		runFrame(1'b1, 120);
		setupFrame(1'b1, 1'b1);	// New setup right after the restart
		applyStart();
		runFrame(1'b1, 0);
		$display("Simulation completed successfully");
		$finish;
	end
endmodule

`default_nettype wire

// File: compile.f
scalerPkg.sv
lineBuffer.sv
lineWriter.sv
coeffGen.sv
blendPipe.sv
scaleControl.sv
streamScaler.sv
tbStreamScaler.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module tbStreamScaler -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/VtbStreamScaler)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
